// File: all.f
hw/pc_mux_pkg.sv
hw/tmr_pkg.sv
hw/next_pc_select.sv
hw/tmr_voter.sv
hw/breakage_counter.sv
hw/tmr_health_monitor.sv
hw/pc_tmr_top.sv
tests/pc_tmr_asserts.sv
tests/pc_tmr_tb.sv

// File: hw/breakage_counter.sv
////////////////////////////////////////////////////////////////////////////
// Saturating up/down error counter for one replica
// Sticky broken flag set on threshold or by software
////////////////////////////////////////////////////////////////////////////

module breakage_counter #(
        parameter int unsigned INCREMENT = 4,
        parameter int unsigned DECREMENT = 1,
        parameter int unsigned THRESHOLD = 16,
        parameter int unsigned COUNT_W   = 6
) (
        input  logic clk,
        input  logic arst_n_i,
        input  logic err_i,
        input  logic set_broken_i,
        output logic is_broken_o
);

        localparam logic [COUNT_W:0] INC_EXT = (COUNT_W + 1)'(INCREMENT);
        localparam logic [COUNT_W:0] DEC_EXT = (COUNT_W + 1)'(DECREMENT);
        localparam logic [COUNT_W:0] CNT_MAX = {1'b0, {COUNT_W{1'b1}}};

        logic [COUNT_W-1:0] count_q;
        logic [COUNT_W-1:0] count_n;
        logic [COUNT_W:0]   count_up;

        // One extra bit catches overflow before saturation
        assign count_up = {1'b0, count_q} + INC_EXT;

        always_comb begin
                if (err_i) begin
                        count_n = (count_up > CNT_MAX) ? COUNT_W'(CNT_MAX) : COUNT_W'(count_up);
                end else if ({1'b0, count_q} < DEC_EXT) begin
                        count_n = '0;
                end else begin
                        count_n = count_q - COUNT_W'(DEC_EXT);
                end
        end

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        count_q     <= '0;
                        is_broken_o <= 1'b0;
                end else begin
                        count_q <= count_n;
                        // Once broken, stays broken until reset
                        if (set_broken_i || (count_n >= THRESHOLD)) begin
                                is_broken_o <= 1'b1;
                        end
                end
        end

endmodule

// File: hw/next_pc_select.sv
////////////////////////////////////////////////////////////////////////////
// Next-PC selection for one replica
// Also raises the mtvec init strobe on a boot PC set
////////////////////////////////////////////////////////////////////////////

module next_pc_select (
        input  pc_mux_pkg::pc_ctrl_t ctrl_i,
        input  pc_mux_pkg::pc_src_t  src_i,
        output pc_mux_pkg::addr_t    next_pc_o,
        output logic                 mtvec_init_o
);

        pc_mux_pkg::addr_t boot_pc;
        pc_mux_pkg::addr_t exc_pc;

        // Boot address is forced to a word boundary
        assign boot_pc = {src_i.boot_addr[31:2], 2'b00};

        // Exception, interrupt and debug targets
        always_comb begin
                case (ctrl_i.exc_pc_mux)
                        pc_mux_pkg::EXC_PC_EXCEPTION: begin
                                exc_pc = {src_i.m_trap_base_addr,
                                          {pc_mux_pkg::TRAP_OFFSET_W{1'b0}}};
                        end
                        pc_mux_pkg::EXC_PC_IRQ: begin
                                // Vectored mode, one word per cause
                                exc_pc = {src_i.m_trap_base_addr, 1'b0,
                                          ctrl_i.m_exc_vec, 2'b00};
                        end
                        pc_mux_pkg::EXC_PC_DBD: exc_pc = src_i.dm_halt_addr;
                        pc_mux_pkg::EXC_PC_DBE: exc_pc = src_i.dm_exception_addr;
                        default:                exc_pc = src_i.dm_halt_addr;
                endcase
        end

        // Main PC mux
        always_comb begin
                case (ctrl_i.pc_mux)
                        pc_mux_pkg::PC_BOOT:      next_pc_o = boot_pc;
                        pc_mux_pkg::PC_JUMP:      next_pc_o = src_i.jump_target_id;
                        pc_mux_pkg::PC_BRANCH:    next_pc_o = src_i.jump_target_ex;
                        pc_mux_pkg::PC_EXCEPTION: next_pc_o = exc_pc;
                        pc_mux_pkg::PC_MRET:      next_pc_o = src_i.mepc;
                        pc_mux_pkg::PC_DRET:      next_pc_o = src_i.depc;
                        pc_mux_pkg::PC_HWLOOP:    next_pc_o = src_i.hwlp_target;
                        // Refetch the instruction after FENCE.I
                        pc_mux_pkg::PC_FENCEI:    next_pc_o = src_i.pc_id + 32'd4;
                        default:                  next_pc_o = boot_pc;
                endcase
        end

        assign mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == pc_mux_pkg::PC_BOOT);

endmodule

// File: hw/pc_mux_pkg.sv
////////////////////////////////////////////////////////////////////////////
// PC source encodings for the next-PC selector
// Control and address source structs seen by one replica
////////////////////////////////////////////////////////////////////////////

package pc_mux_pkg;

        // Instruction address
        typedef logic [31:0] addr_t;

        // Low address bits below the machine trap base
        localparam int unsigned TRAP_OFFSET_W = 8;

        // Next-PC source, same codes as the core's PC mux
        typedef enum logic [3:0] {
                PC_BOOT      = 4'b0000,
                PC_FENCEI    = 4'b0001,
                PC_JUMP      = 4'b0010,
                PC_BRANCH    = 4'b0011,
                PC_EXCEPTION = 4'b0100,
                PC_MRET      = 4'b0101,
                PC_DRET      = 4'b0111,
                PC_HWLOOP    = 4'b1000
        } pc_mux_e;

        // Target inside the exception path
        typedef enum logic [2:0] {
                EXC_PC_EXCEPTION = 3'b000,
                EXC_PC_IRQ       = 3'b001,
                EXC_PC_DBD       = 3'b010,
                EXC_PC_DBE       = 3'b011
        } exc_pc_mux_e;

        // Control of one replica
        typedef struct packed {
                logic        pc_set;
                pc_mux_e     pc_mux;
                exc_pc_mux_e exc_pc_mux;
                logic [4:0]  m_exc_vec;
        } pc_ctrl_t;

        // Address sources of one replica
        typedef struct packed {
                addr_t                      boot_addr;
                addr_t                      jump_target_id;
                addr_t                      jump_target_ex;
                addr_t                      dm_halt_addr;
                addr_t                      dm_exception_addr;
                addr_t                      mepc;
                addr_t                      depc;
                addr_t                      hwlp_target;
                addr_t                      pc_id;
                logic [31-TRAP_OFFSET_W:0]  m_trap_base_addr;
        } pc_src_t;

endpackage

// File: hw/pc_tmr_top.sv
////////////////////////////////////////////////////////////////////////////
// Fault-tolerant next-PC selector, top level
// Three replicas, address and strobe voters, health monitor
////////////////////////////////////////////////////////////////////////////

module pc_tmr_top #(
        parameter int unsigned INCREMENT = 4,
        parameter int unsigned DECREMENT = 1,
        parameter int unsigned THRESHOLD = 16,
        parameter int unsigned COUNT_W   = 6
) (
        input  logic                   clk,
        input  logic                   arst_n_i,
        input  pc_mux_pkg::pc_ctrl_t   ctrl_i [tmr_pkg::REPLICAS],
        input  pc_mux_pkg::pc_src_t    src_i  [tmr_pkg::REPLICAS],
        input  tmr_pkg::replica_mask_t set_broken_i,
        output pc_mux_pkg::addr_t      branch_addr_o,
        output logic                   csr_mtvec_init_o,
        output tmr_pkg::replica_mask_t is_broken_o,
        output logic                   err_detected_o,
        output logic                   err_corrected_o
);

        pc_mux_pkg::addr_t     next_pc    [tmr_pkg::REPLICAS];
        logic                  mtvec_init [tmr_pkg::REPLICAS];
        tmr_pkg::vote_status_t addr_status;
        tmr_pkg::vote_status_t init_status;

        ////////////////////////////////////////////////////////////////////////////
        // Replicas, each on its own copy of the inputs
        ////////////////////////////////////////////////////////////////////////////

        for (genvar r = 0; r < tmr_pkg::REPLICAS; r++) begin : g_replica
                next_pc_select u_next_pc_select (
                        .ctrl_i       (ctrl_i[r]),
                        .src_i        (src_i[r]),
                        .next_pc_o    (next_pc[r]),
                        .mtvec_init_o (mtvec_init[r])
                );
        end

        ////////////////////////////////////////////////////////////////////////////
        // Voters
        ////////////////////////////////////////////////////////////////////////////

        tmr_voter #(
                .payload_t (pc_mux_pkg::addr_t)
        ) u_addr_voter (
                .replicas_i (next_pc),
                .broken_i   (is_broken_o),
                .voted_o    (branch_addr_o),
                .status_o   (addr_status)
        );

        tmr_voter #(
                .payload_t (logic)
        ) u_init_voter (
                .replicas_i (mtvec_init),
                .broken_i   (is_broken_o),
                .voted_o    (csr_mtvec_init_o),
                .status_o   (init_status)
        );

        // Broken mask feeds back into both voters
        tmr_health_monitor #(
                .INCREMENT (INCREMENT),
                .DECREMENT (DECREMENT),
                .THRESHOLD (THRESHOLD),
                .COUNT_W   (COUNT_W)
        ) u_health_monitor (
                .clk             (clk),
                .arst_n_i        (arst_n_i),
                .addr_status_i   (addr_status),
                .init_status_i   (init_status),
                .set_broken_i    (set_broken_i),
                .is_broken_o     (is_broken_o),
                .err_detected_o  (err_detected_o),
                .err_corrected_o (err_corrected_o)
        );

endmodule

// File: hw/tmr_health_monitor.sv
////////////////////////////////////////////////////////////////////////////
// Merges the voter statuses into top-level error flags
// Holds one breakage counter per replica
////////////////////////////////////////////////////////////////////////////

module tmr_health_monitor #(
        parameter int unsigned INCREMENT = 4,
        parameter int unsigned DECREMENT = 1,
        parameter int unsigned THRESHOLD = 16,
        parameter int unsigned COUNT_W   = 6
) (
        input  logic                   clk,
        input  logic                   arst_n_i,
        input  tmr_pkg::vote_status_t  addr_status_i,
        input  tmr_pkg::vote_status_t  init_status_i,
        input  tmr_pkg::replica_mask_t set_broken_i,
        output tmr_pkg::replica_mask_t is_broken_o,
        output logic                   err_detected_o,
        output logic                   err_corrected_o
);

        // A replica errs if it lost either vote
        tmr_pkg::replica_mask_t replica_err;

        assign replica_err     = addr_status_i.block_err | init_status_i.block_err;
        assign err_detected_o  = addr_status_i.detected | init_status_i.detected;
        assign err_corrected_o = addr_status_i.corrected | init_status_i.corrected;

        for (genvar r = 0; r < tmr_pkg::REPLICAS; r++) begin : g_counter
                breakage_counter #(
                        .INCREMENT (INCREMENT),
                        .DECREMENT (DECREMENT),
                        .THRESHOLD (THRESHOLD),
                        .COUNT_W   (COUNT_W)
                ) u_breakage_counter (
                        .clk          (clk),
                        .arst_n_i     (arst_n_i),
                        .err_i        (replica_err[r]),
                        .set_broken_i (set_broken_i[r]),
                        .is_broken_o  (is_broken_o[r])
                );
        end

endmodule

// File: hw/tmr_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Replica count and mask type for triple modular redundancy
// Status word reported by each majority voter
////////////////////////////////////////////////////////////////////////////

package tmr_pkg;

        // Number of redundant copies
        localparam int unsigned REPLICAS = 3;

        // One bit per replica
        typedef logic [REPLICAS-1:0] replica_mask_t;

        // Voter outcome
        typedef struct packed {
                // Replicas that disagreed with the voted value
                replica_mask_t block_err;
                logic          detected;
                logic          corrected;
        } vote_status_t;

endpackage

// File: hw/tmr_voter.sv
////////////////////////////////////////////////////////////////////////////
// Word-level majority voter over the replicas
// Broken replicas are masked out, payload type set per instance
////////////////////////////////////////////////////////////////////////////

module tmr_voter #(
        parameter type payload_t = logic
) (
        input  payload_t               replicas_i [tmr_pkg::REPLICAS],
        input  tmr_pkg::replica_mask_t broken_i,
        output payload_t               voted_o,
        output tmr_pkg::vote_status_t  status_o
);

        ////////////////////////////////////////////////////////////////////////////
        // Healthy replica bookkeeping
        ////////////////////////////////////////////////////////////////////////////

        int unsigned n_healthy;
        int unsigned lo_idx;
        int unsigned hi_idx;

        always_comb begin
                n_healthy = 0;
                lo_idx    = 0;
                hi_idx    = 0;
                // Walk down so the lowest healthy index wins
                for (int i = tmr_pkg::REPLICAS - 1; i >= 0; i--) begin
                        if (!broken_i[i]) begin
                                n_healthy = n_healthy + 1;
                                lo_idx    = i;
                        end
                end
                for (int i = 0; i < tmr_pkg::REPLICAS; i++) begin
                        if (!broken_i[i]) begin
                                hi_idx = i;
                        end
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Vote
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                logic majority;
                majority = 1'b0;
                voted_o  = replicas_i[0];
                status_o = '0;
                case (n_healthy)
                        tmr_pkg::REPLICAS: begin
                                if (replicas_i[0] == replicas_i[1] ||
                                    replicas_i[0] == replicas_i[2]) begin
                                        voted_o  = replicas_i[0];
                                        majority = 1'b1;
                                end else if (replicas_i[1] == replicas_i[2]) begin
                                        voted_o  = replicas_i[1];
                                        majority = 1'b1;
                                end
                                if (majority) begin
                                        for (int i = 0; i < tmr_pkg::REPLICAS; i++) begin
                                                status_o.block_err[i] = replicas_i[i] != voted_o;
                                        end
                                        status_o.detected  = |status_o.block_err;
                                        status_o.corrected = status_o.detected;
                                end else begin
                                        // All three differ, nothing to correct
                                        status_o.block_err = '1;
                                        status_o.detected  = 1'b1;
                                end
                        end
                        2: begin
                                voted_o = replicas_i[lo_idx];
                                if (replicas_i[lo_idx] != replicas_i[hi_idx]) begin
                                        status_o.block_err[lo_idx] = 1'b1;
                                        status_o.block_err[hi_idx] = 1'b1;
                                        status_o.detected          = 1'b1;
                                end
                        end
                        default: begin
                                // Single survivor or none, no comparison possible
                                voted_o = replicas_i[lo_idx];
                        end
                endcase
        end

endmodule

// File: tests/pc_tmr_asserts.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions on the fault-tolerant next-PC selector
// Bound to the top level
////////////////////////////////////////////////////////////////////////////

module pc_tmr_asserts (
        input logic                   clk,
        input logic                   arst_n_i,
        input pc_mux_pkg::addr_t      branch_addr_i,
        input logic                   mtvec_init_i,
        input tmr_pkg::replica_mask_t is_broken_i,
        input logic                   err_detected_i,
        input logic                   err_corrected_i
);

        // A corrected error is always a detected one
        corrected_implies_detected: assert property (
                @(posedge clk) disable iff (!arst_n_i) err_corrected_i |-> err_detected_i
        ) else $error("Error corrected flag is high while error detected flag is low");

        // Broken flags only clear on reset
        broken_flags_sticky: assert property (
                @(posedge clk) disable iff (!arst_n_i)
                (is_broken_i & $past(is_broken_i)) == $past(is_broken_i)
        ) else $error("A broken flag fell while reset was released");

        // Trap vector init comes with a word-aligned boot address
        init_addr_aligned: assert property (
                @(posedge clk) disable iff (!arst_n_i)
                mtvec_init_i |-> (branch_addr_i[1:0] == 2'b00)
        ) else $error("Trap vector init raised with a misaligned next PC");

endmodule

bind pc_tmr_top pc_tmr_asserts u_asserts (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .branch_addr_i   (branch_addr_o),
        .mtvec_init_i    (csr_mtvec_init_o),
        .is_broken_i     (is_broken_o),
        .err_detected_i  (err_detected_o),
        .err_corrected_i (err_corrected_o)
);

// File: tests/pc_tmr_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the fault-tolerant next-PC selector
// Next-PC and breakage counter models, checker, watchdog, directed tests
////////////////////////////////////////////////////////////////////////////

module pc_tmr_tb;

        localparam int unsigned INC     = 4;
        localparam int unsigned DEC     = 1;
        localparam int unsigned THR     = 16;
        localparam int unsigned CNT_TOP = 63;
        // Five tests, each with its reset, then the cycles of each test
        localparam int unsigned TEST_CYCLES = 5 * 5 + 36 + 6 + 8 + 8 + 3;

        logic                   clk;
        logic                   arst_n_i;
        pc_mux_pkg::pc_ctrl_t   ctrl_i [tmr_pkg::REPLICAS];
        pc_mux_pkg::pc_src_t    src_i  [tmr_pkg::REPLICAS];
        tmr_pkg::replica_mask_t set_broken_i;
        pc_mux_pkg::addr_t      branch_addr_o;
        logic                   csr_mtvec_init_o;
        tmr_pkg::replica_mask_t is_broken_o;
        logic                   err_detected_o;
        logic                   err_corrected_o;

        logic [31:0]            rng_state;
        int unsigned            model_cnt [tmr_pkg::REPLICAS];
        tmr_pkg::replica_mask_t model_brk;

        pc_tmr_top uut (
                .clk              (clk),
                .arst_n_i         (arst_n_i),
                .ctrl_i           (ctrl_i),
                .src_i            (src_i),
                .set_broken_i     (set_broken_i),
                .branch_addr_o    (branch_addr_o),
                .csr_mtvec_init_o (csr_mtvec_init_o),
                .is_broken_o      (is_broken_o),
                .err_detected_o   (err_detected_o),
                .err_corrected_o  (err_corrected_o)
        );

        always #4 clk = ~clk;

        ////////////////////////////////////////////////////////////////////////////
        // Stimulus helpers and reference models
        ////////////////////////////////////////////////////////////////////////////

        function automatic logic [31:0] xorshift32();
                rng_state = rng_state ^ (rng_state << 13);
                rng_state = rng_state ^ (rng_state >> 17);
                rng_state = rng_state ^ (rng_state << 5);
                return rng_state;
        endfunction

        function automatic pc_mux_pkg::pc_src_t random_sources();
                pc_mux_pkg::pc_src_t s;
                // Shift in random words until every field is covered
                for (int i = 0; i < 10; i++) begin
                        s = {s[$bits(s)-33:0], xorshift32()};
                end
                return s;
        endfunction

        function automatic pc_mux_pkg::pc_ctrl_t jump_ctrl();
                pc_mux_pkg::pc_ctrl_t c;
                c            = '0;
                c.pc_set     = 1'b1;
                c.pc_mux     = pc_mux_pkg::PC_JUMP;
                return c;
        endfunction

        function automatic pc_mux_pkg::addr_t expected_next_pc(input pc_mux_pkg::pc_ctrl_t c,
                                                               input pc_mux_pkg::pc_src_t s);
                pc_mux_pkg::addr_t pc;
                pc = s.boot_addr & 32'hffff_fffc;
                case (c.pc_mux)
                        pc_mux_pkg::PC_JUMP:   pc = s.jump_target_id;
                        pc_mux_pkg::PC_BRANCH: pc = s.jump_target_ex;
                        pc_mux_pkg::PC_MRET:   pc = s.mepc;
                        pc_mux_pkg::PC_DRET:   pc = s.depc;
                        pc_mux_pkg::PC_HWLOOP: pc = s.hwlp_target;
                        pc_mux_pkg::PC_FENCEI: pc = s.pc_id + 32'd4;
                        pc_mux_pkg::PC_EXCEPTION: begin
                                case (c.exc_pc_mux)
                                        pc_mux_pkg::EXC_PC_EXCEPTION:
                                                pc = {s.m_trap_base_addr, 8'h00};
                                        pc_mux_pkg::EXC_PC_IRQ:
                                                pc = {s.m_trap_base_addr, 1'b0, c.m_exc_vec, 2'b00};
                                        pc_mux_pkg::EXC_PC_DBD: pc = s.dm_halt_addr;
                                        pc_mux_pkg::EXC_PC_DBE: pc = s.dm_exception_addr;
                                        default: pc = 'x;
                                endcase
                        end
                        default: ;
                endcase
                return pc;
        endfunction

        // One clock edge of the saturating breakage counters
        task automatic counter_model_step(input tmr_pkg::replica_mask_t errs,
                                          input tmr_pkg::replica_mask_t forced);
                for (int r = 0; r < tmr_pkg::REPLICAS; r++) begin
                        if (errs[r]) begin
                                model_cnt[r] = (model_cnt[r] + INC > CNT_TOP) ?
                                               CNT_TOP : model_cnt[r] + INC;
                        end else begin
                                model_cnt[r] = (model_cnt[r] < DEC) ? 0 : model_cnt[r] - DEC;
                        end
                        if (model_cnt[r] >= THR || forced[r]) begin
                                model_brk[r] = 1'b1;
                        end
                end
        endtask

        task automatic expect_equal(input string test, input logic [31:0] exp,
                                    input logic [31:0] act);
                if (act !== exp) begin
                        $display("ERROR %s: expected %h, actual %h", test, exp, act);
                        $display("** FAIL **");
                        $fatal(1, "Mismatch in test %s", test);
                end
        endtask

        task automatic apply_reset();
                @(negedge clk);
                arst_n_i     = 1'b0;
                set_broken_i = '0;
                repeat (4) @(negedge clk);
                arst_n_i  = 1'b1;
                model_cnt = '{default: 0};
                model_brk = '0;
        endtask

        task automatic set_replicas(input pc_mux_pkg::pc_ctrl_t c, input pc_mux_pkg::pc_src_t s);
                for (int r = 0; r < tmr_pkg::REPLICAS; r++) begin
                        ctrl_i[r] = c;
                        src_i[r]  = s;
                end
        endtask

        // Combinational outputs first, then the broken mask after the next edge
        task automatic run_cycle(input string test, input pc_mux_pkg::addr_t exp_addr,
                                 input logic exp_init, input logic exp_det, input logic exp_cor,
                                 input tmr_pkg::replica_mask_t errs);
                #1;
                expect_equal(test, exp_addr, branch_addr_o);
                expect_equal(test, exp_init, csr_mtvec_init_o);
                expect_equal(test, exp_det, err_detected_o);
                expect_equal(test, exp_cor, err_corrected_o);
                @(posedge clk);
                counter_model_step(errs, set_broken_i);
                @(negedge clk);
                expect_equal(test, model_brk, is_broken_o);
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Directed tests
        ////////////////////////////////////////////////////////////////////////////

        task automatic path_selection();
                pc_mux_pkg::pc_mux_e  codes [9];
                pc_mux_pkg::pc_ctrl_t c;
                pc_mux_pkg::pc_src_t  s;
                codes = '{pc_mux_pkg::PC_BOOT, pc_mux_pkg::PC_FENCEI, pc_mux_pkg::PC_JUMP,
                          pc_mux_pkg::PC_BRANCH, pc_mux_pkg::PC_EXCEPTION, pc_mux_pkg::PC_MRET,
                          pc_mux_pkg::PC_DRET, pc_mux_pkg::PC_HWLOOP,
                          pc_mux_pkg::pc_mux_e'(4'b0110)};
                apply_reset();
                for (int i = 0; i < 9; i++) begin
                        for (int j = 0; j < 4; j++) begin
                                c.pc_set     = j[0];
                                c.pc_mux     = codes[i];
                                c.exc_pc_mux = pc_mux_pkg::exc_pc_mux_e'(j);
                                c.m_exc_vec  = 5'(xorshift32());
                                s            = random_sources();
                                set_replicas(c, s);
                                // Boot is the first code, pc_set is high on odd steps
                                run_cycle("path_selection", expected_next_pc(c, s),
                                          (i == 0) && j[0],
                                          1'b0, 1'b0, '0);
                        end
                end
        endtask

        task automatic single_fault_masked();
                pc_mux_pkg::pc_src_t s;
                apply_reset();
                for (int r = 0; r < tmr_pkg::REPLICAS; r++) begin
                        s = random_sources();
                        set_replicas(jump_ctrl(), s);
                        src_i[r].jump_target_id = ~s.jump_target_id;
                        run_cycle("single_fault", s.jump_target_id, 1'b0, 1'b1, 1'b1,
                                  tmr_pkg::replica_mask_t'(1 << r));
                        set_replicas(jump_ctrl(), s);
                        run_cycle("single_fault", s.jump_target_id, 1'b0, 1'b0, 1'b0, '0);
                end
        endtask

        task automatic persistent_fault_breakage();
                pc_mux_pkg::pc_src_t s;
                apply_reset();
                s = random_sources();
                for (int i = 0; i < 4; i++) begin
                        set_replicas(jump_ctrl(), s);
                        src_i[1].jump_target_id = s.jump_target_id ^ 32'h0000_0040;
                        run_cycle("persistent_fault", s.jump_target_id, 1'b0, 1'b1, 1'b1, 3'b010);
                        expect_equal("persistent_fault", (i == 3) ? 3'b010 : 3'b000, is_broken_o);
                end
                for (int i = 0; i < 4; i++) begin
                        set_replicas(jump_ctrl(), s);
                        // Broken replica 1 now disagrees without being counted
                        if (i >= 2) begin
                                src_i[1].jump_target_id = ~s.jump_target_id;
                        end
                        run_cycle("persistent_fault", s.jump_target_id, 1'b0, 1'b0, 1'b0, '0);
                end
                expect_equal("persistent_fault", 3'b010, is_broken_o);
        endtask

        task automatic counter_decrement();
                pc_mux_pkg::pc_src_t s;
                apply_reset();
                s = random_sources();
                for (int i = 0; i < 8; i++) begin
                        set_replicas(jump_ctrl(), s);
                        if (i < 3 || i >= 6) begin
                                src_i[0].jump_target_id = s.jump_target_id + 32'd4;
                                run_cycle("decrement", s.jump_target_id, 1'b0, 1'b1, 1'b1, 3'b001);
                        end else begin
                                run_cycle("decrement", s.jump_target_id, 1'b0, 1'b0, 1'b0, '0);
                        end
                end
                expect_equal("decrement", 3'b001, is_broken_o);
        endtask

        task automatic forced_breakage();
                pc_mux_pkg::pc_src_t s;
                apply_reset();
                s = random_sources();
                set_replicas(jump_ctrl(), s);
                set_broken_i = 3'b100;
                run_cycle("forced_break", s.jump_target_id, 1'b0, 1'b0, 1'b0, '0);
                set_broken_i = '0;
                // Two healthy replicas left, so the mismatch cannot be corrected
                // Replica 2 sides with replica 1 and would outvote replica 0 if it counted
                for (int i = 0; i < 2; i++) begin
                        set_replicas(jump_ctrl(), s);
                        src_i[1].jump_target_id = s.jump_target_id + 32'd8;
                        src_i[2].jump_target_id = s.jump_target_id + 32'd8;
                        run_cycle("forced_break", s.jump_target_id, 1'b0, 1'b1, 1'b0, 3'b011);
                end
                expect_equal("forced_break", 3'b100, is_broken_o);
        endtask

        initial begin
                clk          = 1'b0;
                arst_n_i     = 1'b0;
                ctrl_i       = '{default: '0};
                src_i        = '{default: '0};
                set_broken_i = '0;
                rng_state    = 32'h774c_4558;
                path_selection();
                single_fault_masked();
                persistent_fault_breakage();
                counter_decrement();
                forced_breakage();
                $display("** PASS **");
                $finish;
        end

        // Watchdog
        initial begin
                #(2 * TEST_CYCLES * 8);
                $display("Watchdog timeout, the tests did not finish in time");
                $display("** FAIL **");
                $fatal(1, "Watchdog timeout");
        end

endmodule
